// File: design/master_pkg.sv
`default_nettype none

package master_pkg;

  // ==============================
  // apb register port
  // ==============================
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  localparam logic [APB_ADDR_W-1:0] ADDR_MASTER_CTL = 8'h00;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS     = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_ERR        = 8'h08;

  // sw flr request, self clearing
  localparam int CTL_FLR_BIT = 0;

  // status layout, flr state sits in 1:0
  localparam int STATUS_IDLE_BIT = 2;

  // ==============================
  // sticky errors and units
  // ==============================
  localparam int ERR_W             = 3;
  localparam int ERR_APB_SEQ       = 0;
  localparam int ERR_FLR_BOTH      = 1;
  localparam int ERR_IDLE_MISMATCH = 2;

  localparam int NUM_UNITS = 8;

  // ==============================
  // flr sequencer
  // ==============================
  typedef enum logic [1:0] {
    FLRSM_INACTIVE           = 2'd0,
    FLRSM_PREP_OFF           = 2'd1,
    FLRSM_PWRGOOD_RST_ACTIVE = 2'd2
  } flrsm_state_t;

  localparam int PWRGOOD_RST_CYCLES = 8;
  localparam int PWRGOOD_CNT_W      = $clog2(PWRGOOD_RST_CYCLES);
  localparam logic [PWRGOOD_CNT_W-1:0] PWRGOOD_CNT_LAST =
    PWRGOOD_CNT_W'(PWRGOOD_RST_CYCLES - 1);

endpackage

`default_nettype wire

// File: design/master_cfg_apb.sv
`timescale 1ns/1ps
`default_nettype none

module master_cfg_apb (
  input  wire                                 i_clk,
  input  wire                                 i_rst_b,
  input  wire                                 i_psel,
  input  wire                                 i_penable,
  input  wire                                 i_pwrite,
  input  wire [master_pkg::APB_ADDR_W-1:0]    i_paddr,
  input  wire [master_pkg::APB_DATA_W-1:0]    i_pwdata,
  output logic [master_pkg::APB_DATA_W-1:0]   o_prdata,
  output logic                                o_pready,
  output logic                                o_pslverr,
  input  wire master_pkg::flrsm_state_t       i_flr_state,
  input  wire                                 i_unit_idle,
  input  wire [master_pkg::ERR_W-1:0]         i_err_set,
  output logic                                o_sw_flr_pulse,
  output logic [master_pkg::ERR_W-1:0]        o_err
);

  logic                                setup_f;
  logic                                access;
  logic                                wr_access;
  logic                                hit_ctl;
  logic                                hit_status;
  logic                                hit_err;
  logic [master_pkg::APB_DATA_W-1:0]   master_ctl_f;
  logic [master_pkg::ERR_W-1:0]        err_f;
  logic [master_pkg::APB_DATA_W-1:0]   status_val;

  // ==============================
  // apb phase tracking
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      setup_f <= 1'b0;
    end else begin
      setup_f <= i_psel & ~i_penable;
    end
  end

  // zero wait states so an access completes in its first cycle
  assign access    = i_psel & i_penable & setup_f;
  assign wr_access = access & i_pwrite;

  assign hit_ctl    = (i_paddr == master_pkg::ADDR_MASTER_CTL);
  assign hit_status = (i_paddr == master_pkg::ADDR_STATUS);
  assign hit_err    = (i_paddr == master_pkg::ADDR_ERR);

  assign o_pready  = access;
  assign o_pslverr = access & (~(hit_ctl | hit_status | hit_err) | (i_pwrite & hit_status));

  // ==============================
  // registers
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      master_ctl_f <= '0;
    end else if (wr_access & hit_ctl) begin
      master_ctl_f <= i_pwdata;
    end else begin
      // flr request bit drops after one cycle
      master_ctl_f[master_pkg::CTL_FLR_BIT] <= 1'b0;
    end
  end

  assign o_sw_flr_pulse = master_ctl_f[master_pkg::CTL_FLR_BIT];

  // w1c where a new set beats a clear
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      err_f <= '0;
    end else if (wr_access & hit_err) begin
      err_f <= (err_f & ~i_pwdata[master_pkg::ERR_W-1:0]) | i_err_set;
    end else begin
      err_f <= err_f | i_err_set;
    end
  end

  assign o_err = err_f;

  // ==============================
  // read mux
  // ==============================
  always_comb begin
    status_val                              = '0;
    status_val[1:0]                         = i_flr_state;
    status_val[master_pkg::STATUS_IDLE_BIT] = i_unit_idle;
  end

  always_comb begin
    o_prdata = '0;
    if (access & ~i_pwrite) begin
      if (hit_ctl) begin
        o_prdata = master_ctl_f;
      end else if (hit_status) begin
        o_prdata = status_val;
      end else if (hit_err) begin
        o_prdata[master_pkg::ERR_W-1:0] = err_f;
      end
    end
  end

  // ready never lasts past the single access cycle
  a_pready_one_cycle: assert property (@(posedge i_clk) disable iff (~i_rst_b)
    o_pready |=> !o_pready)
    else $error("pready held beyond a single apb access cycle");

endmodule

`default_nettype wire

// File: design/master_flr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module master_flr_unit (
  input  wire                            i_clk,
  input  wire                            i_rst_b,
  input  wire                            i_flr_req,
  input  wire                            i_sw_flr_pulse,
  input  wire                            i_unit_idle,
  output master_pkg::flrsm_state_t       o_flr_state,
  output logic                           o_flr_prep,
  output logic                           o_pwrgood_rst_b
);

  logic                                   flr_req_f;
  logic                                   flr_bus_edge;
  logic                                   sw_triggered_f;
  logic                                   sw_triggered_nxt;
  master_pkg::flrsm_state_t               flrsm_state_f;
  master_pkg::flrsm_state_t               flrsm_state_nxt;
  logic [master_pkg::PWRGOOD_CNT_W-1:0]   rst_cnt_f;
  logic [master_pkg::PWRGOOD_CNT_W-1:0]   rst_cnt_nxt;
  logic                                   pwrgood_rst_b_f;

  assign flr_bus_edge = i_flr_req & ~flr_req_f;

  // ==============================
  // next state
  // ==============================
  always_comb begin
    flrsm_state_nxt  = flrsm_state_f;
    sw_triggered_nxt = sw_triggered_f;
    rst_cnt_nxt      = rst_cnt_f;
    case (flrsm_state_f)
      master_pkg::FLRSM_INACTIVE: begin
        // sw pulse wins when both land together
        if (i_sw_flr_pulse | flr_bus_edge) begin
          flrsm_state_nxt  = master_pkg::FLRSM_PREP_OFF;
          sw_triggered_nxt = i_sw_flr_pulse;
        end
      end
      master_pkg::FLRSM_PREP_OFF: begin
        // wait for drained units
        if (i_unit_idle) begin
          rst_cnt_nxt     = '0;
          flrsm_state_nxt = sw_triggered_f ? master_pkg::FLRSM_PWRGOOD_RST_ACTIVE
                                           : master_pkg::FLRSM_INACTIVE;
        end
      end
      master_pkg::FLRSM_PWRGOOD_RST_ACTIVE: begin
        rst_cnt_nxt = rst_cnt_f + 1'b1;
        if (rst_cnt_f == master_pkg::PWRGOOD_CNT_LAST) begin
          flrsm_state_nxt = master_pkg::FLRSM_INACTIVE;
        end
      end
      default: begin
        flrsm_state_nxt = master_pkg::FLRSM_INACTIVE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      flr_req_f       <= 1'b0;
      flrsm_state_f   <= master_pkg::FLRSM_INACTIVE;
      sw_triggered_f  <= 1'b0;
      rst_cnt_f       <= '0;
      pwrgood_rst_b_f <= 1'b1;
    end else begin
      flr_req_f       <= i_flr_req;
      flrsm_state_f   <= flrsm_state_nxt;
      sw_triggered_f  <= sw_triggered_nxt;
      rst_cnt_f       <= rst_cnt_nxt;
      pwrgood_rst_b_f <= (flrsm_state_nxt != master_pkg::FLRSM_PWRGOOD_RST_ACTIVE);
    end
  end

  assign o_flr_state     = flrsm_state_f;
  assign o_flr_prep      = (flrsm_state_f == master_pkg::FLRSM_PREP_OFF);
  assign o_pwrgood_rst_b = pwrgood_rst_b_f;

  // ==============================
  // checks
  // ==============================
  a_pwrgood_sw_only: assert property (@(posedge i_clk) disable iff (~i_rst_b)
    !o_pwrgood_rst_b |-> sw_triggered_f)
    else $error("pwrgood reset issued for a bus triggered flr");

  a_pwrgood_in_state: assert property (@(posedge i_clk) disable iff (~i_rst_b)
    !o_pwrgood_rst_b |-> (flrsm_state_f == master_pkg::FLRSM_PWRGOOD_RST_ACTIVE))
    else $error("pwrgood reset low outside PWRGOOD_RST_ACTIVE");

endmodule

`default_nettype wire

// File: design/master_idle_agg.sv
`timescale 1ns/1ps
`default_nettype none

module master_idle_agg (
  input  wire                              i_clk,
  input  wire                              i_rst_b,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_idle,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_pipeidle,
  output logic                             o_unit_idle
);

  logic [master_pkg::NUM_UNITS-1:0]   unit_both_f;
  logic                               unit_idle_f;

  // ==============================
  // two stage idle pipe
  // ==============================

  // a unit counts as idle only with both reports high
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      unit_both_f <= '0;
    end else begin
      unit_both_f <= i_unit_idle & i_unit_pipeidle;
    end
  end

  // all units drained
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      unit_idle_f <= 1'b0;
    end else begin
      unit_idle_f <= &unit_both_f;
    end
  end

  assign o_unit_idle = unit_idle_f;

  a_unit_idle_known: assert property (@(posedge i_clk) disable iff (~i_rst_b)
    !$isunknown(o_unit_idle))
    else $error("unit idle is unknown");

endmodule

`default_nettype wire

// File: design/master_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module master_monitor (
  input  wire                              i_clk,
  input  wire                              i_rst_b,
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_flr_req,
  input  wire                              i_sw_flr_pulse,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_idle,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_pipeidle,
  output logic [master_pkg::ERR_W-1:0]     o_err_set
);

  logic                             psel_f;
  logic                             penable_f;
  logic                             flr_req_f;
  logic                             flr_bus_edge;
  logic [master_pkg::ERR_W-1:0]     err_nxt;

  // ==============================
  // history of watched inputs
  // ==============================
  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      psel_f    <= 1'b0;
      penable_f <= 1'b0;
      flr_req_f <= 1'b0;
    end else begin
      psel_f    <= i_psel;
      penable_f <= i_penable;
      flr_req_f <= i_flr_req;
    end
  end

  assign flr_bus_edge = i_flr_req & ~flr_req_f;

  // ==============================
  // forbidden combinations
  // ==============================
  always_comb begin
    err_nxt = '0;
    // enable phase with no select the cycle before
    err_nxt[master_pkg::ERR_APB_SEQ]       = i_penable & ~penable_f & ~psel_f;
    err_nxt[master_pkg::ERR_FLR_BOTH]      = flr_bus_edge & i_sw_flr_pulse;
    // idle claimed while the pipe still busy
    err_nxt[master_pkg::ERR_IDLE_MISMATCH] = |(i_unit_idle & ~i_unit_pipeidle);
  end

  always_ff @(posedge i_clk or negedge i_rst_b) begin
    if (~i_rst_b) begin
      o_err_set <= '0;
    end else begin
      o_err_set <= err_nxt;
    end
  end

  a_err_set_known: assert property (@(posedge i_clk) disable iff (~i_rst_b)
    !$isunknown(o_err_set))
    else $error("error set vector is unknown");

endmodule

`default_nettype wire

// File: design/master_core.sv
`timescale 1ns/1ps
`default_nettype none

module master_core (
  input  wire                              prim_freerun_clk,
  input  wire                              prim_freerun_prim_gated_rst_b_sync,
  input  wire                              i_psel,
  input  wire                              i_penable,
  input  wire                              i_pwrite,
  input  wire [master_pkg::APB_ADDR_W-1:0] i_paddr,
  input  wire [master_pkg::APB_DATA_W-1:0] i_pwdata,
  output logic [master_pkg::APB_DATA_W-1:0] o_prdata,
  output logic                             o_pready,
  output logic                             o_pslverr,
  input  wire                              i_flr_req,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_idle,
  input  wire [master_pkg::NUM_UNITS-1:0]  i_unit_pipeidle,
  output logic                             o_pwrgood_rst_b,
  output logic                             o_flr_prep,
  output logic                             o_irq_err
);

  logic                             sw_flr_pulse;
  master_pkg::flrsm_state_t         flr_state;
  logic                             unit_idle;
  logic [master_pkg::ERR_W-1:0]     err_set;
  logic [master_pkg::ERR_W-1:0]     err;

  master_cfg_apb i_master_cfg_apb (
    .i_clk          (prim_freerun_clk),
    .i_rst_b        (prim_freerun_prim_gated_rst_b_sync),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .o_prdata       (o_prdata),
    .o_pready       (o_pready),
    .o_pslverr      (o_pslverr),
    .i_flr_state    (flr_state),
    .i_unit_idle    (unit_idle),
    .i_err_set      (err_set),
    .o_sw_flr_pulse (sw_flr_pulse),
    .o_err          (err)
  );

  master_flr_unit i_master_flr_unit (
    .i_clk           (prim_freerun_clk),
    .i_rst_b         (prim_freerun_prim_gated_rst_b_sync),
    .i_flr_req       (i_flr_req),
    .i_sw_flr_pulse  (sw_flr_pulse),
    .i_unit_idle     (unit_idle),
    .o_flr_state     (flr_state),
    .o_flr_prep      (o_flr_prep),
    .o_pwrgood_rst_b (o_pwrgood_rst_b)
  );

  master_idle_agg i_master_idle_agg (
    .i_clk           (prim_freerun_clk),
    .i_rst_b         (prim_freerun_prim_gated_rst_b_sync),
    .i_unit_idle     (i_unit_idle),
    .i_unit_pipeidle (i_unit_pipeidle),
    .o_unit_idle     (unit_idle)
  );

  master_monitor i_master_monitor (
    .i_clk           (prim_freerun_clk),
    .i_rst_b         (prim_freerun_prim_gated_rst_b_sync),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_flr_req       (i_flr_req),
    .i_sw_flr_pulse  (sw_flr_pulse),
    .i_unit_idle     (i_unit_idle),
    .i_unit_pipeidle (i_unit_pipeidle),
    .o_err_set       (err_set)
  );

  // interrupt on any sticky error
  assign o_irq_err = |err;

endmodule

`default_nettype wire

// File: testbench/tb_master_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_master_core;

  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DLY       = 2;
  localparam int RST_CYCLES      = 5;
  localparam int NUM_REG_TXN     = 48;
  localparam int NUM_FLR_ROUNDS  = 3;
  localparam int NUM_IDLE_ROUNDS = 8;
  localparam int FLR_GUARD       = 40;
  localparam int RUN_CYCLES      = RST_CYCLES + NUM_REG_TXN * 2 +
    (NUM_FLR_ROUNDS * 2 + 1) * (FLR_GUARD * 2 + 8) + NUM_IDLE_ROUNDS * 14 + 40;
  localparam int WATCHDOG_NS     = RUN_CYCLES * CLK_PERIOD * 2;

  logic                                  prim_freerun_clk;
  logic                                  prim_freerun_prim_gated_rst_b_sync;
  logic                                  psel;
  logic                                  penable;
  logic                                  pwrite;
  logic [master_pkg::APB_ADDR_W-1:0]     paddr;
  logic [master_pkg::APB_DATA_W-1:0]     pwdata;
  logic                                  flr_req;
  logic [master_pkg::NUM_UNITS-1:0]      unit_idle;
  logic [master_pkg::NUM_UNITS-1:0]      unit_pipeidle;
  wire  [master_pkg::APB_DATA_W-1:0]     o_prdata;
  wire                                   o_pready;
  wire                                   o_pslverr;
  wire                                   o_pwrgood_rst_b;
  wire                                   o_flr_prep;
  wire                                   o_irq_err;

  // reference model state
  logic                                  m_setup;
  logic                                  m_psel_f;
  logic                                  m_pen_f;
  logic                                  m_req_f;
  logic [master_pkg::APB_DATA_W-1:0]     m_ctl;
  logic [master_pkg::ERR_W-1:0]          m_err;
  logic [master_pkg::ERR_W-1:0]          m_err_set;
  logic [master_pkg::NUM_UNITS-1:0]      m_both;
  logic                                  m_idle;
  logic                                  m_sw;
  int                                    m_cnt;
  master_pkg::flrsm_state_t              m_state;

  int                                    model_errs = 0;
  int                                    seq_errs = 0;
  int                                    pwrgood_low_cnt = 0;
  logic [31:0]                           lfsr_state = 32'h1d58_cc5f;

  master_core master_core_i (
    .prim_freerun_clk                   (prim_freerun_clk),
    .prim_freerun_prim_gated_rst_b_sync (prim_freerun_prim_gated_rst_b_sync),
    .i_psel                             (psel),
    .i_penable                          (penable),
    .i_pwrite                           (pwrite),
    .i_paddr                            (paddr),
    .i_pwdata                           (pwdata),
    .o_prdata                           (o_prdata),
    .o_pready                           (o_pready),
    .o_pslverr                          (o_pslverr),
    .i_flr_req                          (flr_req),
    .i_unit_idle                        (unit_idle),
    .i_unit_pipeidle                    (unit_pipeidle),
    .o_pwrgood_rst_b                    (o_pwrgood_rst_b),
    .o_flr_prep                         (o_flr_prep),
    .o_irq_err                          (o_irq_err)
  );

  initial begin
    prim_freerun_clk = 1'b0;
    forever #(CLK_PERIOD / 2) prim_freerun_clk = ~prim_freerun_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests completed");
    $display("Simulation failed");
    $finish;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  function automatic void show_error(input string what, input logic [31:0] got,
                                     input logic [31:0] exp);
    $display("** Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
  endfunction

  // ==============================
  // cycle model
  // ==============================
  always @(posedge prim_freerun_clk or negedge prim_freerun_prim_gated_rst_b_sync) begin
    logic acc;
    logic bus_edge;
    if (!prim_freerun_prim_gated_rst_b_sync) begin
      m_setup   <= 1'b0;
      m_psel_f  <= 1'b0;
      m_pen_f   <= 1'b0;
      m_req_f   <= 1'b0;
      m_ctl     <= '0;
      m_err     <= '0;
      m_err_set <= '0;
      m_both    <= '0;
      m_idle    <= 1'b0;
      m_sw      <= 1'b0;
      m_cnt     <= 0;
      m_state   <= master_pkg::FLRSM_INACTIVE;
    end else begin
      acc      = psel & penable & m_setup;
      bus_edge = flr_req & ~m_req_f;
      m_setup  <= psel & ~penable;
      m_psel_f <= psel;
      m_pen_f  <= penable;
      m_req_f  <= flr_req;
      if (acc && pwrite && paddr == master_pkg::ADDR_MASTER_CTL) begin
        m_ctl <= pwdata;
      end else begin
        m_ctl[master_pkg::CTL_FLR_BIT] <= 1'b0;
      end
      if (acc && pwrite && paddr == master_pkg::ADDR_ERR) begin
        m_err <= (m_err & ~pwdata[master_pkg::ERR_W-1:0]) | m_err_set;
      end else begin
        m_err <= m_err | m_err_set;
      end
      m_err_set[master_pkg::ERR_APB_SEQ]       <= penable & ~m_pen_f & ~m_psel_f;
      m_err_set[master_pkg::ERR_FLR_BOTH]      <= bus_edge & m_ctl[master_pkg::CTL_FLR_BIT];
      m_err_set[master_pkg::ERR_IDLE_MISMATCH] <= |(unit_idle & ~unit_pipeidle);
      m_both <= unit_idle & unit_pipeidle;
      m_idle <= &m_both;
      case (m_state)
        master_pkg::FLRSM_INACTIVE: begin
          if (m_ctl[master_pkg::CTL_FLR_BIT] || bus_edge) begin
            m_state <= master_pkg::FLRSM_PREP_OFF;
            m_sw    <= m_ctl[master_pkg::CTL_FLR_BIT];
          end
        end
        master_pkg::FLRSM_PREP_OFF: begin
          m_cnt <= 0;
          if (m_idle && m_sw) begin
            m_state <= master_pkg::FLRSM_PWRGOOD_RST_ACTIVE;
          end else if (m_idle) begin
            m_state <= master_pkg::FLRSM_INACTIVE;
          end
        end
        default: begin
          m_cnt <= m_cnt + 1;
          if (m_cnt == master_pkg::PWRGOOD_RST_CYCLES - 1) begin
            m_state <= master_pkg::FLRSM_INACTIVE;
          end
        end
      endcase
    end
  end

  // outputs compared mid cycle
  always @(negedge prim_freerun_clk) begin
    logic        acc;
    logic        exp_slverr;
    logic [31:0] exp_rdata;
    if (prim_freerun_prim_gated_rst_b_sync) begin
      acc       = psel & penable & m_setup;
      exp_rdata = '0;
      if (acc && !pwrite) begin
        case (paddr)
          master_pkg::ADDR_MASTER_CTL: exp_rdata = m_ctl;
          master_pkg::ADDR_STATUS:     exp_rdata = {29'd0, m_idle, m_state};
          master_pkg::ADDR_ERR:        exp_rdata = {29'd0, m_err};
          default:                     exp_rdata = '0;
        endcase
      end
      exp_slverr = acc & ((paddr != master_pkg::ADDR_MASTER_CTL &&
                           paddr != master_pkg::ADDR_STATUS &&
                           paddr != master_pkg::ADDR_ERR) ||
                          (pwrite && paddr == master_pkg::ADDR_STATUS));
      assert (o_pready === acc && o_pslverr === exp_slverr) else begin
        show_error("pready/pslverr", {o_pready, o_pslverr}, {acc, exp_slverr});
        model_errs++;
      end
      assert (o_prdata === exp_rdata) else begin
        show_error("prdata", o_prdata, exp_rdata);
        model_errs++;
      end
      assert (o_flr_prep === (m_state == master_pkg::FLRSM_PREP_OFF) &&
              o_pwrgood_rst_b === (m_state != master_pkg::FLRSM_PWRGOOD_RST_ACTIVE)) else begin
        show_error("prep/pwrgood", {o_flr_prep, o_pwrgood_rst_b}, m_state);
        model_errs++;
      end
      assert (o_irq_err === |m_err) else begin
        show_error("irq_err", o_irq_err, |m_err);
        model_errs++;
      end
      if (!o_pwrgood_rst_b) begin
        pwrgood_low_cnt++;
      end
    end
  end

  // ==============================
  // stimulus helpers
  // ==============================
  task automatic next_cycle();
    @(posedge prim_freerun_clk);
    #(DRIVE_DLY);
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
    logic exp_err;
    exp_err = (addr != master_pkg::ADDR_MASTER_CTL && addr != master_pkg::ADDR_STATUS &&
               addr != master_pkg::ADDR_ERR) || (wr && addr == master_pkg::ADDR_STATUS);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;
    @(negedge prim_freerun_clk);
    rdata = o_prdata;
    assert (o_pready && o_pslverr == exp_err) else begin
      show_error("apb access response", {o_pready, o_pslverr}, {1'b1, exp_err});
      seq_errs++;
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // mostly busy units with an occasional full drain
  task automatic drive_idle_random();
    logic [1:0]                       sel;
    logic [master_pkg::NUM_UNITS-1:0] pipe;
    sel  = 2'(take_bits(2));
    pipe = master_pkg::NUM_UNITS'(take_bits(master_pkg::NUM_UNITS));
    if (sel == 2'b11) begin
      unit_idle     = '1;
      unit_pipeidle = '1;
    end else begin
      unit_pipeidle = pipe;
      unit_idle     = pipe & master_pkg::NUM_UNITS'(take_bits(master_pkg::NUM_UNITS));
    end
  endtask

  task automatic run_flr(input logic sw, input logic bus);
    logic [31:0] rdata;
    int          low_start;
    int          guard;
    low_start = pwrgood_low_cnt;
    if (sw) begin
      apb_xfer(1'b1, master_pkg::ADDR_MASTER_CTL, 32'h1 << master_pkg::CTL_FLR_BIT, rdata);
    end
    flr_req = bus;
    next_cycle();
    assert (o_flr_prep) else begin
      show_error("flr_prep after trigger", o_flr_prep, 1);
      seq_errs++;
    end
    guard = 0;
    while ((o_flr_prep || !o_pwrgood_rst_b) && guard < FLR_GUARD) begin
      drive_idle_random();
      if (sw) begin
        apb_xfer(1'b0, master_pkg::ADDR_STATUS, '0, rdata);
      end else begin
        next_cycle();
      end
      guard++;
    end
    if (o_flr_prep || !o_pwrgood_rst_b) begin
      $display("flr sequence did not return to inactive within %0d steps", FLR_GUARD);
      seq_errs++;
    end
    flr_req       = 1'b0;
    unit_idle     = '0;
    unit_pipeidle = '0;
    next_cycle();
    assert (pwrgood_low_cnt - low_start == (sw ? master_pkg::PWRGOOD_RST_CYCLES : 0)) else begin
      show_error("pwrgood low cycles", pwrgood_low_cnt - low_start,
                 sw ? master_pkg::PWRGOOD_RST_CYCLES : 0);
      seq_errs++;
    end
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    logic [31:0]                      rdata;
    logic [31:0]                      wdata;
    logic [31:0]                      last_ctl;
    logic [7:0]                       addr;
    logic [1:0]                       sel;
    logic                             wr;
    logic                             collide;
    logic [master_pkg::NUM_UNITS-1:0] viol;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    flr_req       = 1'b0;
    unit_idle     = '0;
    unit_pipeidle = '0;
    prim_freerun_prim_gated_rst_b_sync = 1'b0;
    repeat (RST_CYCLES) @(posedge prim_freerun_clk);
    #(DRIVE_DLY);
    prim_freerun_prim_gated_rst_b_sync = 1'b1;
    next_cycle();

    // register access with the flr request bit kept clear
    last_ctl = '0;
    for (int t = 0; t < NUM_REG_TXN; t++) begin
      sel   = 2'(take_bits(2));
      addr  = (sel == 2'd0) ? master_pkg::ADDR_MASTER_CTL :
              (sel == 2'd1) ? master_pkg::ADDR_ERR :
              (sel == 2'd2) ? master_pkg::ADDR_STATUS : 8'(take_bits(8));
      wr    = 1'(take_bits(1));
      wdata = take_bits(32) & ~32'h1;
      apb_xfer(wr, addr, wdata, rdata);
      if (wr && addr == master_pkg::ADDR_MASTER_CTL) begin
        last_ctl = wdata;
      end else if (addr == master_pkg::ADDR_MASTER_CTL) begin
        assert (rdata == last_ctl) else begin
          show_error("ctl readback", rdata, last_ctl);
          seq_errs++;
        end
      end
    end

    for (int r = 0; r < NUM_FLR_ROUNDS; r++) begin
      run_flr(1'b0, 1'b1);
      run_flr(1'b1, 1'b0);
    end

    // idle reported without pipe idle
    for (int r = 0; r < NUM_IDLE_ROUNDS; r++) begin
      viol          = master_pkg::NUM_UNITS'(1) << take_bits(3);
      unit_idle     = master_pkg::NUM_UNITS'(take_bits(master_pkg::NUM_UNITS)) | viol;
      unit_pipeidle = master_pkg::NUM_UNITS'(take_bits(master_pkg::NUM_UNITS)) & ~viol;
      next_cycle();
      unit_idle     = '0;
      unit_pipeidle = '0;
      apb_xfer(1'b0, master_pkg::ADDR_ERR, '0, rdata);
      assert (rdata[master_pkg::ERR_IDLE_MISMATCH] && o_irq_err) else begin
        show_error("idle mismatch flag", {rdata[master_pkg::ERR_IDLE_MISMATCH], o_irq_err}, 3);
        seq_errs++;
      end
      // w1c with a fresh violation now and then on the access cycle
      collide = 1'(take_bits(1));
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = master_pkg::ADDR_ERR;
      pwdata  = 32'h1 << master_pkg::ERR_IDLE_MISMATCH;
      unit_idle = collide ? viol : '0;
      next_cycle();
      penable   = 1'b1;
      unit_idle = '0;
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      apb_xfer(1'b0, master_pkg::ADDR_ERR, '0, rdata);
      assert (rdata[master_pkg::ERR_IDLE_MISMATCH] == collide) else begin
        show_error("idle mismatch after clear", rdata[master_pkg::ERR_IDLE_MISMATCH], collide);
        seq_errs++;
      end
      apb_xfer(1'b1, master_pkg::ADDR_ERR, 32'h7, rdata);
    end

    // both triggers together and the sw path wins
    run_flr(1'b1, 1'b1);
    apb_xfer(1'b0, master_pkg::ADDR_ERR, '0, rdata);
    assert (rdata[master_pkg::ERR_FLR_BOTH]) else begin
      show_error("flr both flag", rdata, 32'h1 << master_pkg::ERR_FLR_BOTH);
      seq_errs++;
    end
    apb_xfer(1'b1, master_pkg::ADDR_ERR, 32'h7, rdata);

    // penable with no setup cycle, raised out of an idle bus cycle
    next_cycle();
    penable = 1'b1;
    next_cycle();
    penable = 1'b0;
    next_cycle();
    apb_xfer(1'b0, master_pkg::ADDR_ERR, '0, rdata);
    assert (rdata[master_pkg::ERR_APB_SEQ] && o_irq_err) else begin
      show_error("apb sequence flag", rdata, 32'h1 << master_pkg::ERR_APB_SEQ);
      seq_errs++;
    end
    apb_xfer(1'b1, master_pkg::ADDR_ERR, 32'h7, rdata);
    next_cycle();

    $display("errors: model compare %0d, sequence checks %0d", model_errs, seq_errs);
    if (model_errs == 0 && seq_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
design/master_pkg.sv
design/master_cfg_apb.sv
design/master_flr_unit.sv
design/master_idle_agg.sv
design/master_monitor.sv
design/master_core.sv
testbench/tb_master_core.sv

// File: Makefile
SIM      := verilator
TOP      := tb_master_core
FILELIST := sources.f
FLAGS    := --binary --timing --assert -j 0
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))
LOG      := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
